// ==== hw/dnc_sort_pkg.sv ====
// DNC sort stage package: sizes, index widths and controller state encoding

package dnc_sort_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Usage value width, also PHI_OUT and SIZE_N_IN
  localparam int DATA_SIZE = 16;

  // Buffer capacity in entries
  localparam int MAX_N = 16;

  // Element index or buffer address
  localparam int INDEX_SIZE = $clog2(MAX_N);

  // Counters that must hold MAX_N itself
  localparam int COUNT_SIZE = $clog2(MAX_N + 1);

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  // Idle, then load of u(j), then sort, then free list out
  typedef enum logic [1:0] {
    IDLE_STATE   = 2'd0,
    LOAD_STATE   = 2'd1,
    SORT_STATE   = 2'd2,
    OUTPUT_STATE = 2'd3
  } sort_state_t;

endpackage : dnc_sort_pkg

// ==== hw/dnc_sort_pair_if.sv ====
// Compare-exchange pair bus between sort engine and sort buffer

`timescale 1ns/1ns

interface dnc_sort_pair_if
  import dnc_sort_pkg::*;
();

  // Lower entry of the pair, upper one sits at pair_addr+1
  logic [INDEX_SIZE-1:0] pair_addr;

  // Values at pair_addr and pair_addr+1
  logic [DATA_SIZE-1:0]  lo_value;
  logic [DATA_SIZE-1:0]  hi_value;

  // Exchange both entries at the next edge
  logic                  swap;

  // Sequencer side
  modport engine (
    output pair_addr,
    output swap,
    input  lo_value,
    input  hi_value
  );

  // Storage side
  modport buffer (
    input  pair_addr,
    input  swap,
    output lo_value,
    output hi_value
  );

endinterface : dnc_sort_pair_if

// ==== hw/dnc_sort_buffer.sv ====
// Sort buffer: register array of usage values with original indices

`timescale 1ns/1ns

module dnc_sort_buffer
  import dnc_sort_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,

  // Load port from the controller
  input  logic                  load_en,
  input  logic [INDEX_SIZE-1:0] load_addr,
  input  logic [DATA_SIZE-1:0]  load_value,

  // Free list read port
  input  logic [INDEX_SIZE-1:0] rd_addr,
  output logic [INDEX_SIZE-1:0] rd_index,

  // Compare-exchange pair
  dnc_sort_pair_if.buffer       pair
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Usage value per entry
  logic [DATA_SIZE-1:0]  value_mem [MAX_N];

  // Original element index j per entry
  logic [INDEX_SIZE-1:0] index_mem [MAX_N];

  // Upper entry of the current pair
  logic [INDEX_SIZE-1:0] hi_addr;

  assign hi_addr = pair.pair_addr + 1'b1;

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // Empty buffer holds identity order
      for (int i = 0; i < MAX_N; i++) begin
        value_mem[i] <= '0;
        index_mem[i] <= INDEX_SIZE'(i);
      end
    end else if (load_en) begin
      // Index remembers where the value came in
      value_mem[load_addr] <= load_value;
      index_mem[load_addr] <= load_addr;
    end else if (pair.swap) begin
      // Whole entries move, value and index together
      value_mem[pair.pair_addr] <= value_mem[hi_addr];
      index_mem[pair.pair_addr] <= index_mem[hi_addr];
      value_mem[hi_addr]        <= value_mem[pair.pair_addr];
      index_mem[hi_addr]        <= index_mem[pair.pair_addr];
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Pair values for the engine comparator
  assign pair.lo_value = value_mem[pair.pair_addr];
  assign pair.hi_value = value_mem[hi_addr];

  // Sorted index for stream-out
  assign rd_index = index_mem[rd_addr];

endmodule : dnc_sort_buffer

// ==== hw/dnc_sort_engine.sv ====
// Sort engine: odd-even transposition sequencer, one compare-exchange per cycle

`timescale 1ns/1ns

module dnc_sort_engine
  import dnc_sort_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,

  // Launch from the controller with the element count
  input  logic                  sort_start,
  input  logic [COUNT_SIZE-1:0] n,
  output logic                  sort_done,

  // Compare-exchange pair
  dnc_sort_pair_if.engine       pair
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Pass schedule running
  logic                  busy;

  // Count latched at launch
  logic [COUNT_SIZE-1:0] n_reg;

  // Current pass p, pairs start at p mod 2
  logic [COUNT_SIZE-1:0] pass_cnt;

  // Lower address of the pair under compare
  logic [INDEX_SIZE-1:0] pair_addr_reg;

  // Upper address of the following pair in this pass
  logic [COUNT_SIZE-1:0] next_upper;
  logic                  last_pair;

  // Next pass number
  logic [COUNT_SIZE-1:0] pass_next;
  logic                  pass_next_empty;

  ////////////////////////////////////////
  // Schedule decode
  ////////////////////////////////////////

  // Pass ends when the next upper address reaches n
  assign next_upper = COUNT_SIZE'(pair_addr_reg) + COUNT_SIZE'(3);
  assign last_pair  = (next_upper >= n_reg);

  assign pass_next = pass_cnt + 1'b1;

  // Odd pass holds no pair for n of 2
  assign pass_next_empty = pass_next[0] && (n_reg <= COUNT_SIZE'(2));

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy          <= 1'b0;
      sort_done     <= 1'b0;
      n_reg         <= '0;
      pass_cnt      <= '0;
      pair_addr_reg <= '0;
    end else begin
      // Done is a single-cycle pulse
      sort_done <= 1'b0;

      if (!busy) begin
        if (sort_start) begin
          n_reg         <= n;
          pass_cnt      <= '0;
          pair_addr_reg <= '0;
          // Single element needs no compare
          if (n < COUNT_SIZE'(2)) begin
            sort_done <= 1'b1;
          end else begin
            busy <= 1'b1;
          end
        end
      end else if (last_pair) begin
        if ((pass_next == n_reg) || pass_next_empty) begin
          // All n passes through
          busy      <= 1'b0;
          sort_done <= 1'b1;
        end else begin
          pass_cnt      <= pass_next;
          pair_addr_reg <= INDEX_SIZE'(pass_next[0]);
        end
      end else begin
        // Pairs in one pass step by two
        pair_addr_reg <= pair_addr_reg + INDEX_SIZE'(2);
      end
    end
  end

  ////////////////////////////////////////
  // Compare-exchange
  ////////////////////////////////////////

  assign pair.pair_addr = pair_addr_reg;

  // Strictly greater only, equal values keep lower index first
  assign pair.swap = busy && (pair.lo_value > pair.hi_value);

endmodule : dnc_sort_engine

// ==== hw/dnc_sort_vector.sv ====
// Sort vector controller: loads u(j), launches the sort and streams the free list phi

`timescale 1ns/1ns

module dnc_sort_vector
  import dnc_sort_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,

  // Host control
  input  logic                  START,
  output logic                  READY,
  input  logic                  U_IN_ENABLE,
  output logic                  U_OUT_ENABLE,
  output logic                  PHI_OUT_ENABLE,

  // Host data
  input  logic [DATA_SIZE-1:0]  SIZE_N_IN,
  input  logic [DATA_SIZE-1:0]  U_IN,
  output logic [DATA_SIZE-1:0]  PHI_OUT,

  // Buffer load and read
  output logic                  load_en,
  output logic [INDEX_SIZE-1:0] load_addr,
  output logic [DATA_SIZE-1:0]  load_value,
  output logic [INDEX_SIZE-1:0] rd_addr,
  input  logic [INDEX_SIZE-1:0] rd_index,

  // Engine launch
  output logic                  sort_start,
  output logic [COUNT_SIZE-1:0] n,
  input  logic                  sort_done
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  sort_state_t           state;

  // Effective N and the load/output position
  logic [COUNT_SIZE-1:0] n_reg;
  logic [COUNT_SIZE-1:0] cnt;
  logic [COUNT_SIZE-1:0] n_clamped;
  logic                  cnt_last;

  // Marks the cycle of the last PHI_OUT_ENABLE
  logic                  phi_last;

  ////////////////////////////////////////
  // Datapath decode
  ////////////////////////////////////////

  // N forced into 1..MAX_N
  always_comb begin
    if (SIZE_N_IN == '0) begin
      n_clamped = COUNT_SIZE'(1);
    end else if (SIZE_N_IN > DATA_SIZE'(MAX_N)) begin
      n_clamped = COUNT_SIZE'(MAX_N);
    end else begin
      n_clamped = SIZE_N_IN[COUNT_SIZE-1:0];
    end
  end

  assign cnt_last = (cnt == n_reg - 1'b1);

  // Strobes only count while loading
  assign load_en    = (state == LOAD_STATE) && U_IN_ENABLE;
  assign load_addr  = cnt[INDEX_SIZE-1:0];
  assign load_value = U_IN;

  // Output walks addresses 0 to N-1
  assign rd_addr = cnt[INDEX_SIZE-1:0];

  assign n = n_reg;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE_STATE;
      n_reg          <= COUNT_SIZE'(1);
      cnt            <= '0;
      READY          <= 1'b0;
      U_OUT_ENABLE   <= 1'b0;
      PHI_OUT_ENABLE <= 1'b0;
      PHI_OUT        <= '0;
      sort_start     <= 1'b0;
      phi_last       <= 1'b0;
    end else begin
      // Pulses default low
      sort_start     <= 1'b0;
      PHI_OUT_ENABLE <= 1'b0;
      phi_last       <= 1'b0;

      // Echo of each accepted strobe, one cycle late
      U_OUT_ENABLE <= load_en;

      // Completion trails the last index by one cycle
      READY <= phi_last;

      case (state)
        IDLE_STATE: begin
          if (START) begin
            n_reg <= n_clamped;
            cnt   <= '0;
            state <= LOAD_STATE;
          end
        end

        LOAD_STATE: begin
          if (load_en) begin
            cnt <= cnt + 1'b1;
            if (cnt_last) begin
              sort_start <= 1'b1;
              state      <= SORT_STATE;
            end
          end
        end

        SORT_STATE: begin
          // Wait for the engine
          if (sort_done) begin
            cnt   <= '0;
            state <= OUTPUT_STATE;
          end
        end

        OUTPUT_STATE: begin
          PHI_OUT_ENABLE <= 1'b1;
          PHI_OUT        <= DATA_SIZE'(rd_index);
          cnt            <= cnt + 1'b1;
          if (cnt_last) begin
            phi_last <= 1'b1;
            state    <= IDLE_STATE;
          end
        end

        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

endmodule : dnc_sort_vector

// ==== hw/dnc_sort_top.sv ====
// DNC sort stage top: controller, transposition engine and entry buffer

`timescale 1ns/1ns

module dnc_sort_top
  import dnc_sort_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 U_IN_ENABLE,
  output logic                 U_OUT_ENABLE,
  output logic                 PHI_OUT_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] SIZE_N_IN,
  input  logic [DATA_SIZE-1:0] U_IN,
  output logic [DATA_SIZE-1:0] PHI_OUT
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Buffer load and read
  logic                  load_en;
  logic [INDEX_SIZE-1:0] load_addr;
  logic [DATA_SIZE-1:0]  load_value;
  logic [INDEX_SIZE-1:0] rd_addr;
  logic [INDEX_SIZE-1:0] rd_index;

  // Engine handshake
  logic                  sort_start;
  logic [COUNT_SIZE-1:0] n;
  logic                  sort_done;

  // Pair bus engine to buffer
  dnc_sort_pair_if pair_bus ();

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  dnc_sort_vector vector_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .U_IN_ENABLE    (U_IN_ENABLE),
    .U_OUT_ENABLE   (U_OUT_ENABLE),
    .PHI_OUT_ENABLE (PHI_OUT_ENABLE),
    .SIZE_N_IN      (SIZE_N_IN),
    .U_IN           (U_IN),
    .PHI_OUT        (PHI_OUT),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_value     (load_value),
    .rd_addr        (rd_addr),
    .rd_index       (rd_index),
    .sort_start     (sort_start),
    .n              (n),
    .sort_done      (sort_done)
  );

  dnc_sort_engine engine_inst (
    .CLK        (CLK),
    .RST        (RST),
    .sort_start (sort_start),
    .n          (n),
    .sort_done  (sort_done),
    .pair       (pair_bus.engine)
  );

  dnc_sort_buffer buffer_inst (
    .CLK        (CLK),
    .RST        (RST),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_value (load_value),
    .rd_addr    (rd_addr),
    .rd_index   (rd_index),
    .pair       (pair_bus.buffer)
  );

endmodule : dnc_sort_top

// ==== dv/dnc_sort_tb.sv ====
// DNC sort stage testbench: table of usage vectors checked against a stable reference sort

`timescale 1ns/1ns

module dnc_sort_tb
  import dnc_sort_pkg::*;
();

  localparam int NUM_TESTS = 12;
  localparam int TIMEOUT   = 1000;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                 CLK = 1'b0;
  logic                 RST;
  logic                 START;
  logic                 U_IN_ENABLE;
  logic [DATA_SIZE-1:0] SIZE_N_IN;
  logic [DATA_SIZE-1:0] U_IN;
  logic                 READY;
  logic                 U_OUT_ENABLE;
  logic                 PHI_OUT_ENABLE;
  logic [DATA_SIZE-1:0] PHI_OUT;

  // Stimulus table, one row per run
  int                   tab_n      [NUM_TESTS];
  logic [DATA_SIZE-1:0] tab_u      [NUM_TESTS][MAX_N];
  bit                   tab_stray  [NUM_TESTS];

  // Reference free list of the current row
  int                   expected_phi [MAX_N];

  int                   error_count;
  int                   tests_passed;
  int                   tests_failed;
  bit                   timed_out;

  // 20 ns period
  always #10 CLK = ~CLK;

  dnc_sort_top dnc_sort_top_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .U_IN_ENABLE    (U_IN_ENABLE),
    .U_OUT_ENABLE   (U_OUT_ENABLE),
    .PHI_OUT_ENABLE (PHI_OUT_ENABLE),
    .SIZE_N_IN      (SIZE_N_IN),
    .U_IN           (U_IN),
    .PHI_OUT        (PHI_OUT)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    error_count++;
  endtask

  // Fixed rows first, then small-range random rows to force ties
  task automatic fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      tab_stray[t] = 1'b0;
      tab_n[t]     = 1 + int'($urandom % MAX_N);
      for (int j = 0; j < MAX_N; j++) begin
        tab_u[t][j] = DATA_SIZE'($urandom % 4);
      end
    end
    tab_n[0] = 8;
    tab_n[1] = 8;
    tab_n[2] = 6;
    tab_n[3] = 10;
    tab_n[4] = 1;
    tab_n[5] = MAX_N;
    tab_n[6] = MAX_N;
    tab_stray[6] = 1'b1;
    for (int j = 0; j < MAX_N; j++) begin
      tab_u[0][j] = DATA_SIZE'(10 * (j + 1));
      tab_u[1][j] = DATA_SIZE'(100 - 5 * j);
      tab_u[2][j] = DATA_SIZE'(7);
      tab_u[3][j] = DATA_SIZE'((j * 5 + 2) % 4);
      tab_u[4][j] = DATA_SIZE'(42);
      // Wide spread up to the top of the value range
      tab_u[5][j] = DATA_SIZE'((j * 40503) & 16'hffff);
    end
  endtask

  // Stable insertion sort, strictly greater values move up
  task automatic reference_sort(input int t);
    int key;
    int i;
    for (int j = 0; j < MAX_N; j++) begin
      expected_phi[j] = j;
    end
    for (int j = 1; j < tab_n[t]; j++) begin
      key = expected_phi[j];
      i   = j - 1;
      while (i >= 0 && tab_u[t][expected_phi[i]] > tab_u[t][key]) begin
        expected_phi[i + 1] = expected_phi[i];
        i--;
      end
      expected_phi[i + 1] = key;
    end
  endtask

  ////////////////////////////////////////
  // One run
  ////////////////////////////////////////

  task automatic run_test(input int t);
    int n;
    int gap;
    int waited;
    int errs_before;
    bit strobe;
    bit prev_strobe;
    n           = tab_n[t];
    errs_before = error_count;
    prev_strobe = 1'b0;
    reference_sort(t);

    // Launch
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_N_IN <= DATA_SIZE'(n);
    @(negedge CLK);

    // Load with random gaps, echo checked every cycle
    for (int j = 0; j < n; j++) begin
      gap = int'($urandom % 3);
      for (int g = 0; g <= gap; g++) begin
        @(posedge CLK);
        strobe = (g == gap);
        U_IN_ENABLE <= strobe;
        U_IN        <= strobe ? tab_u[t][j] : DATA_SIZE'($urandom);
        // Stray START in the middle of the load
        START       <= strobe && tab_stray[t] && (j == 1);
        @(negedge CLK);
        if (U_OUT_ENABLE !== prev_strobe)
          report_mismatch("U_OUT_ENABLE", 32'(prev_strobe), 32'(U_OUT_ENABLE));
        prev_strobe = strobe;
      end
    end

    // Echo of the last strobe, stray START while sorting
    @(posedge CLK);
    U_IN_ENABLE <= 1'b0;
    START       <= tab_stray[t];
    SIZE_N_IN   <= tab_stray[t] ? DATA_SIZE'(3) : DATA_SIZE'(n);
    @(negedge CLK);
    if (U_OUT_ENABLE !== prev_strobe)
      report_mismatch("U_OUT_ENABLE", 32'(prev_strobe), 32'(U_OUT_ENABLE));
    @(posedge CLK);
    START <= 1'b0;
    @(negedge CLK);

    // Sort latency depends on N
    waited = 0;
    while (PHI_OUT_ENABLE !== 1'b1 && waited < TIMEOUT) begin
      if (U_OUT_ENABLE !== 1'b0)
        report_mismatch("U_OUT_ENABLE", 32'(0), 32'(U_OUT_ENABLE));
      @(negedge CLK);
      waited++;
    end

    if (PHI_OUT_ENABLE !== 1'b1) begin
      $display("Timeout: PHI_OUT_ENABLE never rose in test %0d", t);
      error_count++;
      timed_out = 1'b1;
    end else begin
      // N consecutive indices in sorted order
      for (int i = 0; i < n; i++) begin
        if (PHI_OUT_ENABLE !== 1'b1)
          report_mismatch("PHI_OUT_ENABLE", 32'(1), 32'(PHI_OUT_ENABLE));
        if (PHI_OUT !== DATA_SIZE'(expected_phi[i]))
          report_mismatch("PHI_OUT", 32'(expected_phi[i]), 32'(PHI_OUT));
        if (READY !== 1'b0)
          report_mismatch("READY", 32'(0), 32'(READY));
        @(negedge CLK);
      end
      if (PHI_OUT_ENABLE !== 1'b0)
        report_mismatch("PHI_OUT_ENABLE", 32'(0), 32'(PHI_OUT_ENABLE));
      if (READY !== 1'b1)
        report_mismatch("READY", 32'(1), 32'(READY));
      @(negedge CLK);
      // Single-cycle pulse
      if (READY !== 1'b0)
        report_mismatch("READY", 32'(0), 32'(READY));
    end

    if (error_count == errs_before) begin
      tests_passed++;
      $display("test %0d n=%0d passed", t, n);
    end else begin
      tests_failed++;
      $display("test %0d n=%0d FAILED with %0d errors", t, n, error_count - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'ha0db_bb8d));
    RST          = 1'b1;
    START        = 1'b0;
    U_IN_ENABLE  = 1'b0;
    SIZE_N_IN    = '0;
    U_IN         = '0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    fill_table();

    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);

    // Outputs quiet out of reset
    if (READY !== 1'b0)
      report_mismatch("READY", 32'(0), 32'(READY));
    if (U_OUT_ENABLE !== 1'b0)
      report_mismatch("U_OUT_ENABLE", 32'(0), 32'(U_OUT_ENABLE));
    if (PHI_OUT_ENABLE !== 1'b0)
      report_mismatch("PHI_OUT_ENABLE", 32'(0), 32'(PHI_OUT_ENABLE));
    if (PHI_OUT !== '0)
      report_mismatch("PHI_OUT", 32'(0), 32'(PHI_OUT));

    // Back-to-back runs, no reset in between
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : dnc_sort_tb

// ==== compile.f ====
hw/dnc_sort_pkg.sv
hw/dnc_sort_pair_if.sv
hw/dnc_sort_buffer.sv
hw/dnc_sort_engine.sv
hw/dnc_sort_vector.sv
hw/dnc_sort_top.sv
dv/dnc_sort_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DNC sort stage testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing -Wno-fatal \
  --top-module dnc_sort_tb \
  -f compile.f \
  -o dnc_sort_sim

./obj_dir/dnc_sort_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
